// File: src/fpPkg.sv
// Floating-point adder package with the float, pipeline stage and APB types and the register map
package fpPkg;

    // Bus address as carried on the wire, each slave decodes only its low bits
    localparam int apbPaddrWidth = 32;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } floatWord;

    typedef struct packed {
        logic        signA;
        logic        signB;              // Already flipped for subtract
        logic [7:0]  exponentOut;
        logic [23:0] alignedMantissaA;   // Hidden one included
        logic [23:0] alignedMantissaB;
        logic        guardBit;
        logic        roundBit;
        logic        stickyBit;
        logic        specialValid;
        floatWord    specialResult;
    } alignedPair;

    typedef struct packed {
        logic              sign;
        logic signed [9:0] exponent;     // Wide enough to show underflow and overflow
        logic [23:0]       mantissa;
        logic              guardBit;
        logic              roundBit;
        logic              stickyBit;
        logic              isZero;
        logic              specialValid;
        floatWord          specialResult;
    } normalizedSum;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [apbPaddrWidth-1:0] paddr;
        logic [31:0]              pwdata;
    } apbRequest;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbResponse;

    // Register offsets
    localparam logic [7:0] regOperandA = 8'h00;
    localparam logic [7:0] regOperandB = 8'h04;
    localparam logic [7:0] regControl  = 8'h08;
    localparam logic [7:0] regStatus   = 8'h0C;
    localparam logic [7:0] regResult   = 8'h10;

    // Field positions in control and status
    localparam int controlStart    = 0;
    localparam int controlSubtract = 1;
    localparam int statusDone      = 0;
    localparam int statusSpecial   = 1;

    localparam logic [31:0] quietNan = 32'h7FC00000;

endpackage

// File: src/apbRegisterFile.sv
`timescale 1ns/1ps
// APB register file holding operands, control, status and the captured sum, issues start pulses
module apbRegisterFile #(
    parameter int apbAddrWidth = 8
) (
    input  logic              clk,
    input  logic              rstN,
    input  fpPkg::apbRequest  apbIn,
    output fpPkg::apbResponse apbOut,
    output logic              issue,
    output fpPkg::floatWord   operandA,
    output fpPkg::floatWord   operandB,
    output logic              subtract,
    input  fpPkg::floatWord   result,
    input  logic              resultValid,
    input  logic              resultSpecial
);

    logic [apbAddrWidth-1:0] addr;
    logic                    transfer;
    logic                    writeEn;
    logic                    hitOperandA;
    logic                    hitOperandB;
    logic                    hitControl;
    logic                    hitStatus;
    logic                    hitResult;
    logic                    mapped;
    logic                    startWrite;
    logic                    done;
    logic                    special;
    fpPkg::floatWord         resultReg;

    assign addr     = apbIn.paddr[apbAddrWidth-1:0];
    assign transfer = apbIn.psel & apbIn.penable;   // No wait states, so access phase completes
    assign writeEn  = transfer & apbIn.pwrite;

    assign hitOperandA = (addr == apbAddrWidth'(fpPkg::regOperandA));
    assign hitOperandB = (addr == apbAddrWidth'(fpPkg::regOperandB));
    assign hitControl  = (addr == apbAddrWidth'(fpPkg::regControl));
    assign hitStatus   = (addr == apbAddrWidth'(fpPkg::regStatus));
    assign hitResult   = (addr == apbAddrWidth'(fpPkg::regResult));
    assign mapped      = hitOperandA | hitOperandB | hitControl | hitStatus | hitResult;

    assign startWrite = writeEn & hitControl & apbIn.pwdata[fpPkg::controlStart];

    // Read mux and error response
    always_comb
    begin
        apbOut.prdata = '0;
        if (hitOperandA)
            apbOut.prdata = operandA;
        else if (hitOperandB)
            apbOut.prdata = operandB;
        else if (hitControl)
            apbOut.prdata[fpPkg::controlSubtract] = subtract;   // Start always reads 0
        else if (hitStatus)
        begin
            apbOut.prdata[fpPkg::statusDone]    = done;
            apbOut.prdata[fpPkg::statusSpecial] = special;
        end
        else if (hitResult)
            apbOut.prdata = resultReg;
        apbOut.pready  = 1'b1;
        // Status and result are read only
        apbOut.pslverr = transfer & (~mapped | (apbIn.pwrite & (hitStatus | hitResult)));
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            operandA  <= '0;
            operandB  <= '0;
            subtract  <= 1'b0;
            issue     <= 1'b0;
            done      <= 1'b0;
            special   <= 1'b0;
            resultReg <= '0;
        end
        else
        begin
            issue <= startWrite;                        // One cycle after the start write
            if (writeEn && hitOperandA)
                operandA <= apbIn.pwdata;
            if (writeEn && hitOperandB)
                operandB <= apbIn.pwdata;
            if (writeEn && hitControl)
                subtract <= apbIn.pwdata[fpPkg::controlSubtract];
            if (resultValid)
                resultReg <= result;                    // Later results overwrite in order
            if (startWrite)
            begin
                done    <= 1'b0;
                special <= 1'b0;
            end
            else if (resultValid)
            begin
                done    <= 1'b1;
                special <= resultSpecial;
            end
        end
    end

endmodule

// File: src/exponentAlign.sv
`timescale 1ns/1ps
// First adder stage that classifies operands and aligns the smaller mantissa to the larger exponent
module exponentAlign (
    input  logic              clk,
    input  logic              rstN,
    input  logic              issue,
    input  fpPkg::floatWord   operandA,
    input  fpPkg::floatWord   operandB,
    input  logic              subtract,
    output fpPkg::alignedPair aligned,
    output logic              alignedValid
);

    fpPkg::alignedPair alignNext;
    logic              signBEffective;
    logic              maxExpA;
    logic              maxExpB;
    logic              nanA;
    logic              nanB;
    logic              infA;
    logic              infB;
    logic [23:0]       mantA;
    logic [23:0]       mantB;
    logic              aLarger;
    logic [7:0]        expDiff;
    logic [4:0]        shiftAmount;
    logic [23:0]       smallMant;
    logic [49:0]       shifted;

    assign signBEffective = operandB.sign ^ subtract;

    // Exponent 255 is infinity or NaN
    assign maxExpA = (operandA.exponent == 8'hFF);
    assign maxExpB = (operandB.exponent == 8'hFF);
    assign nanA    = maxExpA && (operandA.mantissa != '0);
    assign nanB    = maxExpB && (operandB.mantissa != '0);
    assign infA    = maxExpA && (operandA.mantissa == '0);
    assign infB    = maxExpB && (operandB.mantissa == '0);

    // Exponent zero flushes to zero and any other exponent gets the hidden one
    assign mantA = (operandA.exponent == 8'h00) ? 24'h0 : {1'b1, operandA.mantissa};
    assign mantB = (operandB.exponent == 8'h00) ? 24'h0 : {1'b1, operandB.mantissa};

    assign aLarger = (operandA.exponent >= operandB.exponent);
    assign expDiff = aLarger ? operandA.exponent - operandB.exponent
                             : operandB.exponent - operandA.exponent;

    // A shift of 26 already pushes every bit into sticky
    assign shiftAmount = (expDiff > 8'd26) ? 5'd26 : expDiff[4:0];
    assign smallMant   = aLarger ? mantB : mantA;
    assign shifted     = {smallMant, 26'b0} >> shiftAmount;

    always_comb
    begin
        alignNext.signA       = operandA.sign;
        alignNext.signB       = signBEffective;
        alignNext.exponentOut = aLarger ? operandA.exponent : operandB.exponent;

        // Larger operand passes unshifted
        alignNext.alignedMantissaA = aLarger ? mantA : shifted[49:26];
        alignNext.alignedMantissaB = aLarger ? shifted[49:26] : mantB;
        alignNext.guardBit         = shifted[25];
        alignNext.roundBit         = shifted[24];
        alignNext.stickyBit        = |shifted[23:0];

        alignNext.specialValid = maxExpA | maxExpB;
        if (nanA || nanB || (infA && infB && (operandA.sign != signBEffective)))
            alignNext.specialResult = fpPkg::quietNan;
        else if (infA)
            alignNext.specialResult = {operandA.sign, 8'hFF, 23'h0};
        else
            alignNext.specialResult = {signBEffective, 8'hFF, 23'h0};   // Only used with B infinite
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            alignedValid <= 1'b0;
            aligned      <= '0;
        end
        else
        begin
            alignedValid <= issue;
            if (issue)
                aligned <= alignNext;
        end
    end

endmodule

// File: src/mantissaAddNormalize.sv
`timescale 1ns/1ps
// Second adder stage that adds or subtracts aligned mantissas and normalizes the sum
module mantissaAddNormalize (
    input  logic                clk,
    input  logic                rstN,
    input  fpPkg::alignedPair   aligned,
    input  logic                alignedValid,
    output fpPkg::normalizedSum sum,
    output logic                sumValid
);

    fpPkg::normalizedSum sumNext;
    logic [2:0]          grs;
    logic                grsOnA;
    logic [26:0]         fullA;
    logic [26:0]         fullB;
    logic [27:0]         total;
    logic                aBigger;
    logic [26:0]         difference;
    logic [26:0]         normalized;
    logic [4:0]          leadingZeros;
    logic signed [9:0]   baseExponent;

    assign grs = {aligned.guardBit, aligned.roundBit, aligned.stickyBit};

    // The shifted operand is the one with the smaller mantissa, so it owns the extra bits
    assign grsOnA = (aligned.alignedMantissaA < aligned.alignedMantissaB);
    assign fullA  = {aligned.alignedMantissaA, grsOnA ? grs : 3'b000};
    assign fullB  = {aligned.alignedMantissaB, grsOnA ? 3'b000 : grs};

    assign total      = {1'b0, fullA} + {1'b0, fullB};
    assign aBigger    = (fullA >= fullB);
    assign difference = aBigger ? fullA - fullB : fullB - fullA;

    // Leading-zero count where the highest set bit wins
    always_comb
    begin
        leadingZeros = 5'd0;
        for (int i = 0; i < 27; i++)
        begin
            if (difference[i])
                leadingZeros = 5'(26 - i);
        end
    end

    assign normalized   = difference << leadingZeros;
    assign baseExponent = $signed({2'b00, aligned.exponentOut});

    always_comb
    begin
        sumNext.specialValid  = aligned.specialValid;
        sumNext.specialResult = aligned.specialResult;
        if (aligned.signA == aligned.signB)
        begin
            sumNext.sign   = aligned.signA;
            sumNext.isZero = (total == '0);
            if (total[27])
            begin
                // Carry out shifts right once
                sumNext.exponent  = baseExponent + 10'sd1;
                sumNext.mantissa  = total[27:4];
                sumNext.guardBit  = total[3];
                sumNext.roundBit  = total[2];
                sumNext.stickyBit = total[1] | total[0];
            end
            else
            begin
                sumNext.exponent  = baseExponent;
                sumNext.mantissa  = total[26:3];
                sumNext.guardBit  = total[2];
                sumNext.roundBit  = total[1];
                sumNext.stickyBit = total[0];
            end
        end
        else
        begin
            sumNext.sign      = aBigger ? aligned.signA : aligned.signB;   // Sign of larger magnitude
            sumNext.isZero    = (difference == '0);
            sumNext.exponent  = baseExponent - $signed({5'b0, leadingZeros});
            sumNext.mantissa  = normalized[26:3];
            sumNext.guardBit  = normalized[2];
            sumNext.roundBit  = normalized[1];
            sumNext.stickyBit = normalized[0];
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            sumValid <= 1'b0;
            sum      <= '0;
        end
        else
        begin
            sumValid <= alignedValid;
            if (alignedValid)
                sum <= sumNext;
        end
    end

endmodule

// File: src/roundPack.sv
`timescale 1ns/1ps
// Last adder stage that rounds to nearest even, resolves special cases and packs the float
module roundPack (
    input  logic                clk,
    input  logic                rstN,
    input  fpPkg::normalizedSum sum,
    input  logic                sumValid,
    output fpPkg::floatWord     result,
    output logic                resultValid,
    output logic                resultSpecial
);

    fpPkg::floatWord   resultNext;
    logic              specialNext;
    logic              roundUp;
    logic [24:0]       rounded;
    logic signed [9:0] finalExponent;
    logic [22:0]       fraction;

    // Ties go to the even mantissa
    assign roundUp = sum.guardBit & (sum.roundBit | sum.stickyBit | sum.mantissa[0]);
    assign rounded = {1'b0, sum.mantissa} + 25'(roundUp);

    // Carry out of the increment leaves 1.0 and bumps the exponent
    assign finalExponent = $signed(sum.exponent) + $signed({9'b0, rounded[24]});
    assign fraction      = rounded[24] ? rounded[23:1] : rounded[22:0];

    always_comb
    begin
        specialNext = 1'b0;
        if (sum.specialValid)
        begin
            resultNext  = sum.specialResult;
            specialNext = 1'b1;
        end
        else if (sum.isZero || finalExponent < 10'sd1)
            resultNext = '0;                                    // Cancellation or underflow
        else if (finalExponent > 10'sd254)
        begin
            resultNext  = {sum.sign, 8'hFF, 23'h0};
            specialNext = 1'b1;
        end
        else
            resultNext = {sum.sign, finalExponent[7:0], fraction};
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            resultValid   <= 1'b0;
            result        <= '0;
            resultSpecial <= 1'b0;
        end
        else
        begin
            resultValid <= sumValid;
            if (sumValid)
            begin
                result        <= resultNext;
                resultSpecial <= specialNext;
            end
        end
    end

endmodule

// File: src/fpAddTop.sv
`timescale 1ns/1ps
// APB floating-point adder top, register file feeding the three-stage add pipeline
module fpAddTop #(
    parameter int apbAddrWidth = 8
) (
    input  logic              clk,
    input  logic              rstN,
    input  fpPkg::apbRequest  apbIn,
    output fpPkg::apbResponse apbOut
);

    logic                issue;
    fpPkg::floatWord     operandA;
    fpPkg::floatWord     operandB;
    logic                subtract;
    fpPkg::alignedPair   aligned;
    logic                alignedValid;
    fpPkg::normalizedSum sum;
    logic                sumValid;
    fpPkg::floatWord     result;
    logic                resultValid;
    logic                resultSpecial;

    apbRegisterFile #(
        .apbAddrWidth(apbAddrWidth)
    ) i_registerFile (
        .clk          (clk),
        .rstN         (rstN),
        .apbIn        (apbIn),
        .apbOut       (apbOut),
        .issue        (issue),
        .operandA     (operandA),
        .operandB     (operandB),
        .subtract     (subtract),
        .result       (result),
        .resultValid  (resultValid),
        .resultSpecial(resultSpecial)
    );

    // Pipeline, one register per stage
    exponentAlign i_align (
        .clk         (clk),
        .rstN        (rstN),
        .issue       (issue),
        .operandA    (operandA),
        .operandB    (operandB),
        .subtract    (subtract),
        .aligned     (aligned),
        .alignedValid(alignedValid)
    );

    mantissaAddNormalize i_addNormalize (
        .clk         (clk),
        .rstN        (rstN),
        .aligned     (aligned),
        .alignedValid(alignedValid),
        .sum         (sum),
        .sumValid    (sumValid)
    );

    roundPack i_roundPack (
        .clk          (clk),
        .rstN         (rstN),
        .sum          (sum),
        .sumValid     (sumValid),
        .result       (result),
        .resultValid  (resultValid),
        .resultSpecial(resultSpecial)
    );

endmodule

// File: verification/fpAddModel.svh
// Reference model of the single-precision adder with flush-to-zero and nearest-even rounding
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

function automatic logic [31:0] expectedSum(input logic [31:0] a, input logic [31:0] b,
                                            input logic subtract);
    logic        signA;
    logic        signB;
    logic [7:0]  expA;
    logic [7:0]  expB;
    logic [23:0] mantA;
    logic [23:0] mantB;
    logic [63:0] wide;
    logic [27:0] fa;        // Carry, 24 mantissa bits, guard, round, sticky
    logic [27:0] fb;
    logic [27:0] v;
    logic [24:0] rounded;
    logic        sign;
    int          e;
    int          diff;
    signA = a[31];
    signB = b[31] ^ subtract;
    expA  = a[30:23];
    expB  = b[30:23];
    if ((expA == 8'hFF && a[22:0] != '0) || (expB == 8'hFF && b[22:0] != '0))
        return fpPkg::quietNan;
    if (expA == 8'hFF && expB == 8'hFF && signA != signB)
        return fpPkg::quietNan;
    if (expA == 8'hFF)
        return {signA, 8'hFF, 23'h0};
    if (expB == 8'hFF)
        return {signB, 8'hFF, 23'h0};
    mantA = (expA == 8'h00) ? 24'h0 : {1'b1, a[22:0]};    // Flush to zero
    mantB = (expB == 8'h00) ? 24'h0 : {1'b1, b[22:0]};
    e     = (expA >= expB) ? expA : expB;
    diff  = (expA >= expB) ? expA - expB : expB - expA;
    if (diff > 40)
        diff = 40;
    fa   = {1'b0, mantA, 3'b000};
    fb   = {1'b0, mantB, 3'b000};
    wide = {((expA >= expB) ? mantB : mantA), 40'h0} >> diff;
    // Everything below the round position collapses into sticky
    if (expA >= expB)
        fb = {1'b0, wide[63:38], |wide[37:0]};
    else
        fa = {1'b0, wide[63:38], |wide[37:0]};
    if (signA == signB)
    begin
        v    = fa + fb;
        sign = signA;
    end
    else if (fa >= fb)
    begin
        v    = fa - fb;
        sign = signA;
    end
    else
    begin
        v    = fb - fa;
        sign = signB;
    end
    if (v == '0)
        return 32'h0;                                      // Exact cancellation
    if (v[27])
    begin
        v = {1'b0, v[27:2], v[1] | v[0]};
        e++;
    end
    while (!v[26])
    begin
        v = v << 1;
        e--;
    end
    rounded = {1'b0, v[26:3]} + 25'(v[2] & (v[1] | v[0] | v[3]));
    if (rounded[24])
    begin
        rounded = rounded >> 1;
        e++;
    end
    if (e < 1)
        return 32'h0;
    if (e > 254)
        return {sign, 8'hFF, 23'h0};
    return {sign, e[7:0], rounded[22:0]};
endfunction

`endif

// File: verification/fpAddTb.sv
`timescale 1ns/1ps
// Testbench for the APB floating-point adder that checks directed and random sums against a model
module fpAddTb;

    localparam int numRandom     = 500;
    localparam int numOps        = numRandom + 40;
    localparam int timeoutCycles = numOps * 40 + 1000;

    logic              clk;
    logic              rstN;
    fpPkg::apbRequest  apbIn;
    fpPkg::apbResponse apbOut;
    int                errorCount;
    integer            seed;
    string             nameQueue[$];
    logic [31:0]       expectedQueue[$];
    logic [31:0]       actualQueue[$];
    logic              specialQueue[$];
    event              resultReady;

    `include "fpAddModel.svh"

    fpAddTop #(
        .apbAddrWidth(8)
    ) i_dut (
        .clk   (clk),
        .rstN  (rstN),
        .apbIn (apbIn),
        .apbOut(apbOut)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    endtask

    // Setup and access phases begin on falling edges and the response is sampled before the rising edge
    task automatic apbTransfer(input logic write, input logic [7:0] addr, input logic [31:0] data,
                               output logic [31:0] rdata, output logic err);
        @(negedge clk);
        apbIn.psel    = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite  = write;
        apbIn.paddr   = 32'(addr);
        apbIn.pwdata  = data;
        @(negedge clk);
        apbIn.penable = 1'b1;
        #1;
        rdata = apbOut.prdata;
        err   = apbOut.pslverr;
        if (apbOut.pready !== 1'b1)
            reportMismatch("pready", 32'h1, 32'(apbOut.pready));
        @(negedge clk);
        apbIn.psel    = 1'b0;
        apbIn.penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] discard;
        apbTransfer(1'b1, addr, data, discard, err);
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apbTransfer(1'b0, addr, 32'h0, data, err);
    endtask

    function automatic logic [31:0] controlWord(input logic sub);
        logic [31:0] word;
        word = '0;
        word[fpPkg::controlStart]    = 1'b1;
        word[fpPkg::controlSubtract] = sub;
        return word;
    endfunction

    task automatic waitDone(output logic [31:0] status);
        logic err;
        status = '0;
        while (!status[fpPkg::statusDone])
            apbRead(fpPkg::regStatus, status, err);
    endtask

    task automatic queueResult(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input logic special);
        nameQueue.push_back(name);
        expectedQueue.push_back(expected);
        actualQueue.push_back(actual);
        specialQueue.push_back(special);
        -> resultReady;
    endtask

    task automatic runOp(input string name, input logic [31:0] a, input logic [31:0] b,
                         input logic sub);
        logic [31:0] status;
        logic [31:0] sum;
        logic        err;
        logic        errAny;
        apbWrite(fpPkg::regOperandA, a, err);
        errAny = err;
        apbWrite(fpPkg::regOperandB, b, err);
        errAny = errAny | err;
        apbWrite(fpPkg::regControl, controlWord(sub), err);
        errAny = errAny | err;
        waitDone(status);
        apbRead(fpPkg::regResult, sum, err);
        errAny = errAny | err;
        if (errAny !== 1'b0)
            reportMismatch({name, " pslverr"}, 32'h0, 32'(errAny));
        queueResult(name, expectedSum(a, b, sub), sum, status[fpPkg::statusSpecial]);
    endtask

    // Exponents lean toward 0, 255 and the neighbour's exponent
    function automatic logic [31:0] randomOperand(input logic [7:0] nearExponent);
        logic [31:0] value;
        int          pick;
        value = $random(seed);
        pick  = $unsigned($random(seed)) % 8;
        if (pick == 0)
            value[30:23] = 8'h00;
        else if (pick == 1)
            value[30:23] = 8'hFF;
        else if (pick == 2)
            value[30:0] = {8'hFF, 23'h0};
        else if (pick < 6)
            value[30:23] = nearExponent + 8'($unsigned($random(seed)) % 5) - 8'd2;
        return value;
    endfunction

    // Compares each read result and its special flag with the model
    initial
    begin
        string       name;
        logic [31:0] expected;
        logic [31:0] actual;
        logic        special;
        logic        expectSpecial;
        forever
        begin
            @(resultReady);
            while (actualQueue.size() > 0)
            begin
                name          = nameQueue.pop_front();
                expected      = expectedQueue.pop_front();
                actual        = actualQueue.pop_front();
                special       = specialQueue.pop_front();
                expectSpecial = (expected[30:23] == 8'hFF);
                if (actual !== expected)
                    reportMismatch(name, expected, actual);
                if (special !== expectSpecial)
                    reportMismatch({name, " special"}, 32'(expectSpecial), 32'(special));
            end
        end
    end

    initial
    begin
        logic [31:0] data;
        logic [31:0] a;
        logic [31:0] b;
        logic        err;
        errorCount = 0;
        seed       = 32'h6707;
        rstN       = 1'b0;
        apbIn      = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        apbRead(fpPkg::regStatus, data, err);
        if (data !== 32'h0)
            reportMismatch("reset status", 32'h0, data);
        apbRead(fpPkg::regResult, data, err);
        if (data !== 32'h0)
            reportMismatch("reset result", 32'h0, data);
        apbRead(8'h20, data, err);
        if (err !== 1'b1)
            reportMismatch("unmapped read pslverr", 32'h1, 32'(err));
        if (data !== 32'h0)
            reportMismatch("unmapped read data", 32'h0, data);
        apbWrite(fpPkg::regResult, 32'hDEADBEEF, err);
        if (err !== 1'b1)
            reportMismatch("result write pslverr", 32'h1, 32'(err));
        apbWrite(fpPkg::regStatus, 32'h3, err);
        if (err !== 1'b1)
            reportMismatch("status write pslverr", 32'h1, 32'(err));
        apbRead(fpPkg::regResult, data, err);
        if (data !== 32'h0)
            reportMismatch("result after bad write", 32'h0, data);

        runOp("equal exponent carry", 32'h3FC00000, 32'h3FA00000, 1'b0);
        runOp("equal exponent subtract", 32'h3FC00000, 32'h3F800000, 1'b1);
        runOp("one plus two", 32'h3F800000, 32'h40000000, 1'b0);
        runOp("diff 23", 32'h4B000000, 32'h3F800000, 1'b0);
        runOp("diff above 26 add", 32'h3F800000, 32'h2F800000, 1'b0);
        runOp("diff above 26 sub", 32'h3F800000, 32'h2F800000, 1'b1);
        runOp("cancel subtract", 32'h40490FDB, 32'h40490FDB, 1'b1);
        runOp("cancel opposite signs", 32'hC0490FDB, 32'h40490FDB, 1'b0);
        runOp("tie even lsb", 32'h3F800000, 32'h33800000, 1'b0);   // Stays at 1.0
        runOp("tie odd lsb", 32'h3F800001, 32'h33800000, 1'b0);
        runOp("sticky below half", 32'h3F800000, 32'h33000001, 1'b0);
        runOp("sticky above half", 32'h3F800000, 32'h33800001, 1'b0);
        runOp("sticky subtract", 32'h3F800000, 32'h33800001, 1'b1);
        runOp("zero plus normal", 32'h00000000, 32'h40400000, 1'b0);
        runOp("normal minus zero", 32'hC1200000, 32'h80000000, 1'b1);
        runOp("negative zeros", 32'h80000000, 32'h00000000, 1'b1);
        runOp("denormal flushed", 32'h00012345, 32'h3F800000, 1'b0);
        runOp("nan plus normal", 32'h7F800001, 32'h3F800000, 1'b0);
        runOp("normal plus nan", 32'h3F800000, 32'hFFC00000, 1'b0);
        runOp("inf plus minus inf", 32'h7F800000, 32'hFF800000, 1'b0);
        runOp("inf minus inf", 32'h7F800000, 32'h7F800000, 1'b1);
        runOp("inf plus inf", 32'hFF800000, 32'hFF800000, 1'b0);
        runOp("inf plus normal", 32'h7F800000, 32'h42000000, 1'b0);
        runOp("normal minus inf", 32'h42000000, 32'h7F800000, 1'b1);
        runOp("overflow", 32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0);
        runOp("underflow", 32'h00800000, 32'h00800001, 1'b1);

        for (int i = 0; i < numRandom; i++)
        begin
            a = randomOperand(8'($random(seed)));
            b = randomOperand(a[30:23]);
            runOp($sformatf("random %0d", i), a, b, 1'($random(seed)));
        end

        // Done clears on the issuing write and the second start wins regResult
        apbWrite(fpPkg::regOperandA, 32'h40A00000, err);
        apbWrite(fpPkg::regOperandB, 32'h3FC00000, err);
        apbWrite(fpPkg::regControl, controlWord(1'b0), err);
        apbRead(fpPkg::regStatus, data, err);
        if (data[fpPkg::statusDone] !== 1'b0)
            reportMismatch("done after start", 32'h0, 32'(data[fpPkg::statusDone]));
        apbWrite(fpPkg::regControl, controlWord(1'b1), err);
        waitDone(data);
        a = data;
        apbRead(fpPkg::regResult, data, err);
        queueResult("back-to-back start", expectedSum(32'h40A00000, 32'h3FC00000, 1'b1), data,
                    a[fpPkg::statusSpecial]);

        @(negedge clk);
        $display("Errors: %0d", errorCount);
        if (errorCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", timeoutCycles);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: fpAddTop.f
+incdir+verification
src/fpPkg.sv
src/apbRegisterFile.sv
src/exponentAlign.sv
src/mantissaAddNormalize.sv
src/roundPack.sv
src/fpAddTop.sv
verification/fpAddTb.sv
